//--- build.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/ref_addr_stage.sv
verilog/ref_bank_rotator.sv
verilog/ref_bank.sv
verilog/ref_window_select.sv
verilog/chroma_fetch_top.sv
dv/tb_chroma_fetch.sv

//--- dv/tb_chroma_fetch.sv
`include "fetch_defs.svh"

module tb_chroma_fetch;

    localparam int CLK_PERIOD = 20;
    localparam int N_RAND     = 150;
    localparam int N_B2B      = 60;
    localparam int N_WRAP     = 8;
    localparam int N_WRAP_OPS = 8;
    localparam int CUR_YS [3] = '{0, 1, 3};
    localparam int PIC_HS [4] = '{40, 100, 130, 201};
    localparam int N_CTX      = 12;
    localparam int STIM_CYCLES = 20 + 4*(`BANK_ROWS+1) + 1 + N_RAND*4 + N_B2B
                               + N_CTX*(256+8) + N_WRAP*(2*N_WRAP_OPS+8) + 32;
    localparam int MARGIN     = 500;

    logic                               clk;
    logic                               rstn;
    logic                               start_i;
    logic                               load_valid_i;
    logic [`ROW_W-1:0]                  load_addr_i;
    fetch_pkg::pel_t [2*`BANK_PELS-1:0] load_data_i;
    logic [`CUR_Y_W-1:0]                cur_y_i;
    logic [`PIC_H_W-1:0]                pic_height_i;
    logic                               rd_en_i;
    fetch_pkg::comp_e                   rd_sel_i;
    logic [`REF_X_W-1:0]                ref_x_i;
    logic [`REF_Y_W-1:0]                ref_y_i;
    fetch_pkg::out_pels_t               pel_o;
    logic                               pel_valid_o;

    // Reference model state
    fetch_pkg::bank_row_t model_u [`NUM_BANKS][`BANK_ROWS];
    fetch_pkg::bank_row_t model_v [`NUM_BANKS][`BANK_ROWS];
    int                   model_rot;
    int                   due_q [$];     // Cycle when each result is due
    fetch_pkg::out_pels_t want_q [$];

    integer seed;
    int     cyc;
    int     errors;
    bit     any_read;

    chroma_fetch_top dut (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic fail_now(input string msg);
        errors++;
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    // ********************
    // Model helpers
    // ********************
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic fetch_pkg::bank_row_t rand_row();
        fetch_pkg::bank_row_t r;
        for (int i = 0; i < `BANK_PELS/4; i++) begin
            r[4*i +: 4] = $random(seed);
        end
        return r;
    endfunction

    // Top and bottom picture edge
    function automatic int clamp_row(input int y, input int cy, input int ph);
        int lim;
        int base;
        int row;
        lim  = (ph - 1) / 2;
        base = cy * `CTU_CROWS;
        if (cy == 0) begin
            row = (y < `Y_MARGIN) ? 0 : y - `Y_MARGIN;
        end else if (base + y - `Y_MARGIN > lim) begin
            row = lim - base + `Y_MARGIN;
        end else begin
            row = y;
        end
        return row & (`BANK_ROWS-1);
    endfunction

    function automatic fetch_pkg::pel_t window_pel(input fetch_pkg::comp_e sel,
                                                   input int row, input int idx);
        int bank;
        if (idx >= 2*`BANK_PELS) begin
            bank = (model_rot + 2) % `NUM_BANKS;
        end else if (idx >= `BANK_PELS) begin
            bank = (model_rot + 3) % `NUM_BANKS;
        end else begin
            bank = model_rot;
        end
        if (sel == fetch_pkg::COMP_V) begin
            return model_v[bank][row][idx % `BANK_PELS];
        end
        return model_u[bank][row][idx % `BANK_PELS];
    endfunction

    // ********************
    // Drivers
    // ********************
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_inputs();
        start_i      = 1'b0;
        load_valid_i = 1'b0;
        load_addr_i  = '0;
        load_data_i  = '0;
        rd_en_i      = 1'b0;
        rd_sel_i     = fetch_pkg::COMP_U;
        ref_x_i      = '0;
        ref_y_i      = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            step();
            clear_inputs();
        end
    endtask

    task automatic drain();
        while (due_q.size() > 0) begin
            idle(1);
        end
    endtask

    task automatic load_row(input int addr);
        fetch_pkg::bank_row_t u;
        fetch_pkg::bank_row_t v;
        int wb;
        u  = rand_row();
        v  = rand_row();
        wb = (model_rot + 1) % `NUM_BANKS;  // Write bank
        step();
        clear_inputs();
        load_valid_i = 1'b1;
        load_addr_i  = addr[`ROW_W-1:0];
        load_data_i  = {u, v};
        model_u[wb][addr] = u;
        model_v[wb][addr] = v;
    endtask

    task automatic start_pulse();
        drain();
        step();
        clear_inputs();
        start_i   = 1'b1;
        model_rot = (model_rot + 1) % `NUM_BANKS;
    endtask

    task automatic set_context(input int cy, input int ph);
        drain();
        cur_y_i      = cy[`CUR_Y_W-1:0];
        pic_height_i = ph[`PIC_H_W-1:0];
    endtask

    task automatic read_req(input fetch_pkg::comp_e sel, input int x, input int y);
        fetch_pkg::out_pels_t want;
        int row;
        row = clamp_row(y, int'(cur_y_i), int'(pic_height_i));
        for (int k = 0; k < `OUT_PELS; k++) begin
            want[k] = window_pel(sel, row, `WIN_PELS - `OUT_PELS - x + k);
        end
        step();
        clear_inputs();
        rd_en_i  = 1'b1;
        rd_sel_i = sel;
        ref_x_i  = x[`REF_X_W-1:0];
        ref_y_i  = y[`REF_Y_W-1:0];
        due_q.push_back(cyc + 4);  // Sampled next edge, result 3 edges later
        want_q.push_back(want);
        any_read = 1'b1;
    endtask

    task automatic random_read(input int y);
        fetch_pkg::comp_e sel;
        int x;
        sel = (rand_below(2) == 1) ? fetch_pkg::COMP_V : fetch_pkg::COMP_U;
        x   = rand_below(`WIN_PELS - `OUT_PELS + 1);
        read_req(sel, x, y);
    endtask

    // ********************
    // Output checker
    // ********************
    always @(negedge clk) begin
        if (rstn) begin
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                assert (pel_valid_o) else
                    fail_now($sformatf("Result valid missing at cycle %0d", cyc));
                assert (pel_o === want_q[0]) else
                    fail_now($sformatf("MISMATCH pel_o expected %h actual %h",
                                       want_q[0], pel_o));
                void'(due_q.pop_front());
                void'(want_q.pop_front());
            end else begin
                assert (!pel_valid_o) else
                    fail_now($sformatf("Result valid without a request at cycle %0d", cyc));
                if (!any_read) begin
                    assert (pel_o === '0) else
                        fail_now($sformatf("MISMATCH pel_o expected %h actual %h",
                                           64'h0, pel_o));
                end
            end
        end
    end

    initial begin
        #((STIM_CYCLES + MARGIN) * CLK_PERIOD);
        fail_now("Timeout, stimulus did not complete in the expected time");
    end

    initial begin
        clk          = 1'b0;
        cyc          = 0;
        seed         = 34393;
        errors       = 0;
        any_read     = 1'b0;
        model_rot    = 0;
        rstn         = 1'b0;
        cur_y_i      = '0;
        pic_height_i = '0;
        clear_inputs();
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
        idle(5);

        // Fill all banks, one write bank per phase
        for (int p = 0; p < `NUM_BANKS; p++) begin
            for (int r = 0; r < `BANK_ROWS; r++) begin
                load_row(r);
            end
            start_pulse();
        end
        start_pulse();

        // Random reads with gaps
        set_context(2, 2048);
        for (int i = 0; i < N_RAND; i++) begin
            random_read(rand_below(256));
            idle(rand_below(4));
        end

        // Three in flight
        drain();
        for (int i = 0; i < N_B2B; i++) begin
            random_read(rand_below(256));
        end

        // ********************
        // Row correction sweep
        // ********************
        foreach (CUR_YS[c]) begin
            foreach (PIC_HS[h]) begin
                set_context(CUR_YS[c], PIC_HS[h]);
                for (int y = 0; y < 256; y++) begin
                    random_read(y);
                end
            end
        end

        // Rotation wrap, loads and reads interleaved
        set_context(2, 2048);
        for (int w = 0; w < N_WRAP; w++) begin
            for (int j = 0; j < N_WRAP_OPS; j++) begin
                load_row(rand_below(`BANK_ROWS));
                random_read(rand_below(256));
            end
            start_pulse();
        end
        for (int j = 0; j < N_WRAP_OPS; j++) begin
            random_read(rand_below(256));
        end

        drain();
        idle(4);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the chroma fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_chroma_fetch -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_chroma_fetch)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- verilog/chroma_fetch_top.sv
`include "fetch_defs.svh"

module chroma_fetch_top (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                start_i,
    input  logic                                load_valid_i,
    input  logic [`ROW_W-1:0]                   load_addr_i,
    input  fetch_pkg::pel_t [2*`BANK_PELS-1:0]  load_data_i,
    input  logic [`CUR_Y_W-1:0]                 cur_y_i,
    input  logic [`PIC_H_W-1:0]                 pic_height_i,
    input  logic                                rd_en_i,
    input  fetch_pkg::comp_e                    rd_sel_i,
    input  logic [`REF_X_W-1:0]                 ref_x_i,
    input  logic [`REF_Y_W-1:0]                 ref_y_i,
    output fetch_pkg::out_pels_t                pel_o,
    output logic                                pel_valid_o
);

    fetch_pkg::bank_row_t  load_u;
    fetch_pkg::bank_row_t  load_v;

    logic                  rd_en_u;
    logic                  rd_en_v;
    logic [`ROW_W-1:0]     rd_row;
    logic [`REF_X_W-1:0]   ref_x;
    fetch_pkg::comp_e      sel;
    fetch_pkg::rot_t       rot;
    logic                  addr_valid;

    logic [`NUM_BANKS-1:0] u_wr_en;
    logic [`ROW_W-1:0]     u_wr_row  [`NUM_BANKS];
    fetch_pkg::bank_row_t  u_wr_data [`NUM_BANKS];
    logic [`NUM_BANKS-1:0] u_rd_en;
    logic [`ROW_W-1:0]     u_rd_row  [`NUM_BANKS];
    fetch_pkg::bank_row_t  u_rows    [`NUM_BANKS];
    logic [`NUM_BANKS-1:0] v_wr_en;
    logic [`ROW_W-1:0]     v_wr_row  [`NUM_BANKS];
    fetch_pkg::bank_row_t  v_wr_data [`NUM_BANKS];
    logic [`NUM_BANKS-1:0] v_rd_en;
    logic [`ROW_W-1:0]     v_rd_row  [`NUM_BANKS];
    fetch_pkg::bank_row_t  v_rows    [`NUM_BANKS];

    // U in the upper half
    assign load_u     = load_data_i[2*`BANK_PELS-1:`BANK_PELS];
    assign load_v     = load_data_i[`BANK_PELS-1:0];
    assign addr_valid = rd_en_u | rd_en_v;

    // ********************
    // Pipeline stages
    // ********************
    ref_addr_stage u_addr (
        .clk, .rstn, .rd_en_i, .rd_sel_i, .ref_x_i, .ref_y_i, .cur_y_i, .pic_height_i,
        .rd_en_u_o (rd_en_u), .rd_en_v_o (rd_en_v), .rd_row_o (rd_row),
        .ref_x_o   (ref_x),   .sel_o     (sel)
    );

    ref_bank_rotator u_rot (
        .clk, .rstn, .start_i, .load_valid_i, .load_addr_i,
        .load_u_i    (load_u),    .load_v_i   (load_v),
        .rd_en_u_i   (rd_en_u),   .rd_en_v_i  (rd_en_v), .rd_row_i (rd_row),
        .u_wr_en_o   (u_wr_en),   .u_wr_row_o (u_wr_row), .u_wr_data_o (u_wr_data),
        .u_rd_en_o   (u_rd_en),   .u_rd_row_o (u_rd_row),
        .v_wr_en_o   (v_wr_en),   .v_wr_row_o (v_wr_row), .v_wr_data_o (v_wr_data),
        .v_rd_en_o   (v_rd_en),   .v_rd_row_o (v_rd_row),
        .rot_o       (rot)
    );

    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
        ref_bank bank_u (
            .clk, .rstn,
            .wr_en_i (u_wr_en[b]), .wr_row_i (u_wr_row[b]), .wr_data_i (u_wr_data[b]),
            .rd_en_i (u_rd_en[b]), .rd_row_i (u_rd_row[b]), .rd_data_o (u_rows[b])
        );
        ref_bank bank_v (
            .clk, .rstn,
            .wr_en_i (v_wr_en[b]), .wr_row_i (v_wr_row[b]), .wr_data_i (v_wr_data[b]),
            .rd_en_i (v_rd_en[b]), .rd_row_i (v_rd_row[b]), .rd_data_o (v_rows[b])
        );
    end

    ref_window_select u_win (
        .clk, .rstn,
        .rot_i    (rot),    .sel_i    (sel),    .ref_x_i (ref_x), .valid_i (addr_valid),
        .u_rows_i (u_rows), .v_rows_i (v_rows),
        .pel_o, .pel_valid_o
    );

endmodule

//--- verilog/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ********************
// Bank geometry
// ********************
`define PEL_W       8
`define BANK_PELS   32
`define BANK_ROWS   64
`define ROW_W       6
`define NUM_BANKS   4

// Read window
`define WIN_PELS    96
`define OUT_PELS    8

// ********************
// Request and picture context
// ********************
`define REF_X_W     7     // Offsets 0 to 88
`define REF_Y_W     8
`define CUR_Y_W     7
`define PIC_H_W     12
`define Y_MARGIN    16    // Vertical search margin
`define CTU_CROWS   32    // Chroma rows per CTU

`endif

//--- verilog/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

    // One chroma sample
    typedef logic [`PEL_W-1:0] pel_t;

    // One bank row, pixel 0 in the low bits
    typedef pel_t [`BANK_PELS-1:0] bank_row_t;

    // Three banks side by side
    typedef pel_t [`WIN_PELS-1:0] window_t;

    typedef pel_t [`OUT_PELS-1:0] out_pels_t;

    typedef enum logic {
        COMP_U = 1'b0,
        COMP_V = 1'b1
    } comp_e;

    // Which bank of each component is the oldest column
    typedef logic [$clog2(`NUM_BANKS)-1:0] rot_t;

endpackage

//--- verilog/ref_addr_stage.sv
`include "fetch_defs.svh"

module ref_addr_stage (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  rd_en_i,
    input  fetch_pkg::comp_e      rd_sel_i,
    input  logic [`REF_X_W-1:0]   ref_x_i,
    input  logic [`REF_Y_W-1:0]   ref_y_i,
    input  logic [`CUR_Y_W-1:0]   cur_y_i,
    input  logic [`PIC_H_W-1:0]   pic_height_i,
    output logic                  rd_en_u_o,
    output logic                  rd_en_v_o,
    output logic [`ROW_W-1:0]     rd_row_o,
    output logic [`REF_X_W-1:0]   ref_x_o,
    output fetch_pkg::comp_e      sel_o
);

    logic                req_en;
    fetch_pkg::comp_e    req_sel;
    logic [`REF_X_W-1:0] req_x;
    logic [`REF_Y_W-1:0] req_y;

    logic [`PIC_H_W:0]   cur_base;   // First chroma row of the current CTU
    logic [`PIC_H_W:0]   ref_y_ext;
    logic [`PIC_H_W:0]   row_sum;
    logic [`PIC_H_W-1:0] pic_hm1;
    logic [`PIC_H_W:0]   bot_lim;    // Last chroma row of the picture
    logic [`PIC_H_W:0]   row_full;

    // Incoming request
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_en <= 1'b0;
        end else begin
            req_en <= rd_en_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            req_sel <= rd_sel_i;
            req_x   <= ref_x_i;
            req_y   <= ref_y_i;
        end
    end

    assign cur_base  = (`PIC_H_W+1)'(cur_y_i * `CTU_CROWS);
    assign ref_y_ext = (`PIC_H_W+1)'(req_y);
    assign row_sum   = cur_base + ref_y_ext - (`PIC_H_W+1)'(`Y_MARGIN);
    assign pic_hm1   = pic_height_i - 1'b1;
    assign bot_lim   = {2'b00, pic_hm1[`PIC_H_W-1:1]};

    // ********************
    // Top and bottom edge correction
    // ********************
    always_comb begin
        if (cur_y_i == '0) begin
            row_full = (req_y < `Y_MARGIN) ? '0 : ref_y_ext - (`PIC_H_W+1)'(`Y_MARGIN);
        end else if (row_sum > bot_lim) begin
            row_full = bot_lim - cur_base + (`PIC_H_W+1)'(`Y_MARGIN); // Repeat last row
        end else begin
            row_full = ref_y_ext;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_en_u_o <= 1'b0;
            rd_en_v_o <= 1'b0;
        end else begin
            rd_en_u_o <= req_en && (req_sel == fetch_pkg::COMP_U);
            rd_en_v_o <= req_en && (req_sel == fetch_pkg::COMP_V);
        end
    end

    // Request payload, held between reads
    always_ff @(posedge clk) begin
        if (req_en) begin
            rd_row_o <= row_full[`ROW_W-1:0];
            ref_x_o  <= req_x;
            sel_o    <= req_sel;
        end
    end

endmodule

//--- verilog/ref_bank.sv
`include "fetch_defs.svh"

module ref_bank (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 wr_en_i,
    input  logic [`ROW_W-1:0]    wr_row_i,
    input  fetch_pkg::bank_row_t wr_data_i,
    input  logic                 rd_en_i,
    input  logic [`ROW_W-1:0]    rd_row_i,
    output fetch_pkg::bank_row_t rd_data_o
);

    fetch_pkg::bank_row_t mem [`BANK_ROWS];

    // ********************
    // Storage
    // ********************
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_row_i] <= wr_data_i;
        end
    end

    // Holds last row between reads
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_row_i];
        end
    end

endmodule

//--- verilog/ref_bank_rotator.sv
`include "fetch_defs.svh"

module ref_bank_rotator (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  start_i,
    input  logic                  load_valid_i,
    input  logic [`ROW_W-1:0]     load_addr_i,
    input  fetch_pkg::bank_row_t  load_u_i,
    input  fetch_pkg::bank_row_t  load_v_i,
    input  logic                  rd_en_u_i,
    input  logic                  rd_en_v_i,
    input  logic [`ROW_W-1:0]     rd_row_i,
    output logic [`NUM_BANKS-1:0] u_wr_en_o,
    output logic [`ROW_W-1:0]     u_wr_row_o  [`NUM_BANKS],
    output fetch_pkg::bank_row_t  u_wr_data_o [`NUM_BANKS],
    output logic [`NUM_BANKS-1:0] u_rd_en_o,
    output logic [`ROW_W-1:0]     u_rd_row_o  [`NUM_BANKS],
    output logic [`NUM_BANKS-1:0] v_wr_en_o,
    output logic [`ROW_W-1:0]     v_wr_row_o  [`NUM_BANKS],
    output fetch_pkg::bank_row_t  v_wr_data_o [`NUM_BANKS],
    output logic [`NUM_BANKS-1:0] v_rd_en_o,
    output logic [`ROW_W-1:0]     v_rd_row_o  [`NUM_BANKS],
    output fetch_pkg::rot_t       rot_o
);

    fetch_pkg::rot_t wr_bank;

    // Advances once per CTU, wraps 3 -> 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rot_o <= '0;
        end else if (start_i) begin
            rot_o <= rot_o + 1'b1;
        end
    end

    assign wr_bank = rot_o + 1'b1;  // Newest column goes here

    // ********************
    // Port steering
    // ********************
    always_comb begin
        for (int b = 0; b < `NUM_BANKS; b++) begin
            if (fetch_pkg::rot_t'(b) == wr_bank) begin
                u_wr_en_o[b]   = load_valid_i;
                u_wr_row_o[b]  = load_addr_i;
                u_wr_data_o[b] = load_u_i;
                u_rd_en_o[b]   = 1'b0;        // Never read while loading
                u_rd_row_o[b]  = '0;
                v_wr_en_o[b]   = load_valid_i;
                v_wr_row_o[b]  = load_addr_i;
                v_wr_data_o[b] = load_v_i;
                v_rd_en_o[b]   = 1'b0;
                v_rd_row_o[b]  = '0;
            end else begin
                u_wr_en_o[b]   = 1'b0;
                u_wr_row_o[b]  = '0;
                u_wr_data_o[b] = '0;
                u_rd_en_o[b]   = rd_en_u_i;
                u_rd_row_o[b]  = rd_row_i;
                v_wr_en_o[b]   = 1'b0;
                v_wr_row_o[b]  = '0;
                v_wr_data_o[b] = '0;
                v_rd_en_o[b]   = rd_en_v_i;
                v_rd_row_o[b]  = rd_row_i;
            end
        end
    end

endmodule

//--- verilog/ref_window_select.sv
`include "fetch_defs.svh"

module ref_window_select (
    input  logic                  clk,
    input  logic                  rstn,
    input  fetch_pkg::rot_t       rot_i,
    input  fetch_pkg::comp_e      sel_i,
    input  logic [`REF_X_W-1:0]   ref_x_i,
    input  logic                  valid_i,
    input  fetch_pkg::bank_row_t  u_rows_i [`NUM_BANKS],
    input  fetch_pkg::bank_row_t  v_rows_i [`NUM_BANKS],
    output fetch_pkg::out_pels_t  pel_o,
    output logic                  pel_valid_o
);

    logic                 valid_q;
    fetch_pkg::rot_t      rot_q;
    fetch_pkg::comp_e     sel_q;
    logic [`REF_X_W-1:0]  x_q;
    fetch_pkg::rot_t      idx_hi;
    fetch_pkg::rot_t      idx_mid;
    fetch_pkg::window_t   win_u;
    fetch_pkg::window_t   win_v;
    fetch_pkg::window_t   win;
    fetch_pkg::out_pels_t pel_sel;

    // ********************
    // Align with bank read
    // ********************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            rot_q <= rot_i;
            sel_q <= sel_i;
            x_q   <= ref_x_i;
        end
    end

    // Oldest column on the left
    assign idx_hi  = rot_q + 2'd2;
    assign idx_mid = rot_q + 2'd3;

    assign win_u = {u_rows_i[idx_hi], u_rows_i[idx_mid], u_rows_i[rot_q]};
    assign win_v = {v_rows_i[idx_hi], v_rows_i[idx_mid], v_rows_i[rot_q]};
    assign win   = (sel_q == fetch_pkg::COMP_V) ? win_v : win_u;

    assign pel_sel = win[(`WIN_PELS-1) - x_q -: `OUT_PELS];  // Pixels 95-x .. 88-x

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pel_valid_o <= 1'b0;
            pel_o       <= '0;
        end else begin
            pel_valid_o <= valid_q;
            if (valid_q) begin
                pel_o <= pel_sel;
            end
        end
    end

endmodule
